//--- vlog.f
rtl/riscv_pkg.sv
rtl/operand_select.sv
rtl/alu.sv
rtl/branch_target.sv
rtl/ex_commit.sv
rtl/execute.sv
tb/execute_sva.sv
tb/execute_tb.sv

//--- run.sh
#!/bin/sh
# build the execute stage testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module execute_tb -f vlog.f -o execute_sim
./obj_dir/execute_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
grep -q "All tests passed" sim.log

//--- tb/execute_tb.sv
// table driven testbench for the execute stage covering ALU, forwarding, redirect and EX/MEM
`timescale 1ns/1ns
`default_nettype none

module execute_tb;

    import riscv_pkg::*;

    localparam int    N_FIXED     = 24;
    localparam int    N_RANDOM    = 6;
    localparam word_t EX_MEM_DATA = 32'h0000_2000;
    localparam word_t MEM_WB_DATA = 32'h0000_0300;

    // fwd is {ex_mem_rs1, ex_mem_rs2, mem_wb_rs1, mem_wb_rs2}
    // ctl is {stall, flush}
    // side and exp_side are {trap, wb_use_mem, write_rd}
    typedef struct packed {
        word_t          pc;
        word_t          rs1;
        word_t          rs2;
        word_t          imm;
        alu_oper1_src_t src1;
        alu_oper2_src_t src2;
        alu_oper_t      op;
        bnj_oper_t      bnj;
        logic [3:0]     fwd;
        logic [1:0]     ctl;
        mem_oper_t      mem;
        logic [2:0]     side;
        reg_addr_t      rd;
        logic           exp_load_pc;
        word_t          exp_new_pc;
        word_t          exp_result;
        word_t          exp_oper2;
        mem_oper_t      exp_mem;
        logic [2:0]     exp_side;
        reg_addr_t      exp_rd;
    } row_t;

    logic           clk_i, rstn_i, stall_i, flush_i;
    word_t          pc_i, rs1_data_i, rs2_data_i, imm_i;
    alu_oper1_src_t alu_oper1_src_i;
    alu_oper2_src_t alu_oper2_src_i;
    alu_oper_t      alu_oper_i;
    bnj_oper_t      bnj_oper_i;
    mem_oper_t      mem_oper_i, mem_oper_o;
    logic           trap_i, wb_use_mem_i, write_rd_i;
    logic           trap_o, wb_use_mem_o, write_rd_o, load_pc_o;
    reg_addr_t      rd_addr_i, rd_addr_o;
    word_t          alu_result_o, alu_oper2_o, new_pc_o;
    logic           forward_ex_mem_rs1_i, forward_ex_mem_rs2_i;
    logic           forward_mem_wb_rs1_i, forward_mem_wb_rs2_i;
    word_t          forward_ex_mem_data_i, forward_mem_wb_data_i;

    row_t   rows[$];
    string  names[$];
    integer seed;

    execute u_execute (.*);

    always #5 clk_i = ~clk_i;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input string what, input word_t exp,
                              input word_t act);
        if (act !== exp)
            stop_with_failure($sformatf("FAILED %s %s: expected %h, actual %h",
                                        name, what, exp, act));
    endtask

    task automatic check_bit(input string name, input string what, input logic exp,
                             input logic act);
        if (act !== exp)
            stop_with_failure($sformatf("FAILED %s %s: expected %b, actual %b",
                                        name, what, exp, act));
    endtask

    task automatic check_mem_oper(input string name, input mem_oper_t exp, input mem_oper_t act);
        if (act !== exp)
            stop_with_failure($sformatf("FAILED %s mem_oper_o: expected %s, actual %s",
                                        name, exp.name(), act.name()));
    endtask

    task automatic check_rd(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp)
            stop_with_failure($sformatf("FAILED %s rd_addr_o: expected %0d, actual %0d",
                                        name, exp, act));
    endtask

    // reference ALU built from the operation rules
    function automatic word_t alu_model(input alu_oper_t op, input word_t a, input word_t b);
        shamt_t sh;
        logic   lt_s;
        sh = b[4:0];
        // differing signs decide a signed compare on their own
        lt_s = (a[31] != b[31]) ? a[31] : (a < b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 32'd1;
            ALU_SEQ:  return {31'd0, a == b};
            ALU_SNEQ: return {31'd0, a != b};
            ALU_SLT:  return {31'd0, lt_s};
            ALU_SGE:  return {31'd0, !lt_s};
            ALU_SLTU: return {31'd0, a < b};
            ALU_SGEU: return {31'd0, !(a < b)};
            ALU_XOR:  return a ^ b;
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return (a >> sh) | ({32{a[31]}} & ~(32'hFFFF_FFFF >> sh));
            default:  return a + b;
        endcase
    endfunction

    task automatic add_row(input string name, input row_t r);
        names.push_back(name);
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row("add_reg", row_t'{32'h100, 32'd7, 32'd5, 32'd0, OPER1_RS1, OPER2_RS2, ALU_ADD,
            BNJ_NONE, 4'b0000, 2'b00, MEM_NOP, 3'b001, 5'd1,
            1'b0, 32'd0, 32'd12, 32'd5, MEM_NOP, 3'b001, 5'd1});
        add_row("sub_imm", row_t'{32'h100, 32'd10, 32'd3, 32'hFFFF_FFFC, OPER1_RS1, OPER2_IMM,
            ALU_SUB, BNJ_NONE, 4'b0000, 2'b00, MEM_NOP, 3'b001, 5'd2,
            1'b0, 32'd0, 32'd14, 32'd3, MEM_NOP, 3'b001, 5'd2});
        add_row("seq_equal", row_t'{32'h100, 32'h1234, 32'h1234, 32'd0, OPER1_RS1, OPER2_RS2,
            ALU_SEQ, BNJ_NONE, 4'b0000, 2'b00, MEM_NOP, 3'b001, 5'd3,
            1'b0, 32'd0, 32'd1, 32'h1234, MEM_NOP, 3'b001, 5'd3});
        add_row("sneq", row_t'{32'h100, 32'h1234, 32'h1235, 32'd0, OPER1_RS1, OPER2_RS2,
            ALU_SNEQ, BNJ_NONE, 4'b0000, 2'b00, MEM_NOP, 3'b001, 5'd4,
            1'b0, 32'd0, 32'd1, 32'h1235, MEM_NOP, 3'b001, 5'd4});
        add_row("slt_neg", row_t'{32'h100, 32'hFFFF_FFF0, 32'd5, 32'd0, OPER1_RS1, OPER2_RS2,
            ALU_SLT, BNJ_NONE, 4'b0000, 2'b00, MEM_NOP, 3'b001, 5'd5,
            1'b0, 32'd0, 32'd1, 32'd5, MEM_NOP, 3'b001, 5'd5});
        add_row("sge_neg", row_t'{32'h100, 32'h8000_0000, 32'hFFFF_FFFF, 32'd0, OPER1_RS1,
            OPER2_RS2, ALU_SGE, BNJ_NONE, 4'b0000, 2'b00, MEM_NOP, 3'b001, 5'd6,
            1'b0, 32'd0, 32'd0, 32'hFFFF_FFFF, MEM_NOP, 3'b001, 5'd6});
        add_row("sltu_neg", row_t'{32'h100, 32'hFFFF_FFF0, 32'd5, 32'd0, OPER1_RS1, OPER2_RS2,
            ALU_SLTU, BNJ_NONE, 4'b0000, 2'b00, MEM_NOP, 3'b001, 5'd7,
            1'b0, 32'd0, 32'd0, 32'd5, MEM_NOP, 3'b001, 5'd7});
        add_row("sgeu_neg", row_t'{32'h100, 32'hFFFF_FFF0, 32'd5, 32'd0, OPER1_RS1, OPER2_RS2,
            ALU_SGEU, BNJ_NONE, 4'b0000, 2'b00, MEM_NOP, 3'b001, 5'd8,
            1'b0, 32'd0, 32'd1, 32'd5, MEM_NOP, 3'b001, 5'd8});
        // rs1 comes from MEM/WB only
        add_row("xor_fwd_wb", row_t'{32'h100, 32'hDEAD, 32'hFF0, 32'd0, OPER1_RS1, OPER2_RS2,
            ALU_XOR, BNJ_NONE, 4'b0010, 2'b00, MEM_LW, 3'b011, 5'd9,
            1'b0, 32'd0, 32'hCF0, 32'hFF0, MEM_LW, 3'b011, 5'd9});
        add_row("or_imm", row_t'{32'h100, 32'h00F0_0000, 32'd1, 32'hF, OPER1_RS1, OPER2_IMM,
            ALU_OR, BNJ_NONE, 4'b0000, 2'b00, MEM_NOP, 3'b001, 5'd10,
            1'b0, 32'd0, 32'h00F0_000F, 32'd1, MEM_NOP, 3'b001, 5'd10});
        // EX/MEM has to win when both selects are set
        add_row("and_fwd_both", row_t'{32'h100, 32'hFFFF, 32'hFFFF, 32'd0, OPER1_RS1, OPER2_RS2,
            ALU_AND, BNJ_NONE, 4'b1111, 2'b00, MEM_NOP, 3'b001, 5'd11,
            1'b0, 32'd0, 32'h2000, 32'h2000, MEM_NOP, 3'b001, 5'd11});
        add_row("sll_big", row_t'{32'h100, 32'd3, 32'd36, 32'd0, OPER1_RS1, OPER2_RS2,
            ALU_SLL, BNJ_NONE, 4'b0000, 2'b00, MEM_NOP, 3'b001, 5'd12,
            1'b0, 32'd0, 32'h30, 32'd36, MEM_NOP, 3'b001, 5'd12});
        add_row("srl_trap", row_t'{32'h100, 32'h8000_0000, 32'd4, 32'd0, OPER1_RS1, OPER2_RS2,
            ALU_SRL, BNJ_NONE, 4'b0000, 2'b00, MEM_NOP, 3'b101, 5'd13,
            1'b0, 32'd0, 32'h0800_0000, 32'd4, MEM_NOP, 3'b101, 5'd13});
        add_row("sra_neg", row_t'{32'h100, 32'h8000_0010, 32'd36, 32'd0, OPER1_RS1, OPER2_RS2,
            ALU_SRA, BNJ_NONE, 4'b0000, 2'b00, MEM_NOP, 3'b001, 5'd14,
            1'b0, 32'd0, 32'hF800_0001, 32'd36, MEM_NOP, 3'b001, 5'd14});
        add_row("lui_zero", row_t'{32'h100, 32'h55, 32'd9, 32'h1234_5000, OPER1_ZERO,
            OPER2_IMM, ALU_ADD, BNJ_NONE, 4'b0000, 2'b00, MEM_NOP, 3'b001, 5'd15,
            1'b0, 32'd0, 32'h1234_5000, 32'd9, MEM_NOP, 3'b001, 5'd15});
        add_row("jal_link", row_t'{32'h200, 32'd0, 32'd0, 32'h40, OPER1_PC, OPER2_PC_INC,
            ALU_ADD, BNJ_JAL, 4'b0000, 2'b00, MEM_NOP, 3'b001, 5'd1,
            1'b1, 32'h240, 32'h200 + PC_INC, 32'd0, MEM_NOP, 3'b001, 5'd1});
        add_row("jalr_fwd", row_t'{32'h300, 32'h9999, 32'd0, 32'h10, OPER1_PC, OPER2_PC_INC,
            ALU_ADD, BNJ_JALR, 4'b1000, 2'b00, MEM_NOP, 3'b001, 5'd1,
            1'b1, 32'h2010, 32'h300 + PC_INC, 32'd0, MEM_NOP, 3'b001, 5'd1});
        add_row("beq_taken", row_t'{32'h400, 32'h77, 32'h77, 32'hFFFF_FFF0, OPER1_RS1,
            OPER2_RS2, ALU_SEQ, BNJ_BRANCH, 4'b0000, 2'b00, MEM_NOP, 3'b000, 5'd0,
            1'b1, 32'h3F0, 32'd1, 32'h77, MEM_NOP, 3'b000, 5'd0});
        add_row("beq_not", row_t'{32'h400, 32'h77, 32'h78, 32'hFFFF_FFF0, OPER1_RS1,
            OPER2_RS2, ALU_SEQ, BNJ_BRANCH, 4'b0000, 2'b00, MEM_NOP, 3'b000, 5'd0,
            1'b0, 32'd0, 32'd0, 32'h78, MEM_NOP, 3'b000, 5'd0});
        // store data follows the forwarded rs2 while operand 2 is the offset
        add_row("store_fwd", row_t'{32'h100, 32'h1000, 32'hBAD, 32'd8, OPER1_RS1, OPER2_IMM,
            ALU_ADD, BNJ_NONE, 4'b0001, 2'b00, MEM_SW, 3'b000, 5'd20,
            1'b0, 32'd0, 32'h1008, 32'h300, MEM_SW, 3'b000, 5'd20});
        add_row("stall", row_t'{32'h100, 32'd1, 32'd2, 32'd0, OPER1_RS1, OPER2_RS2, ALU_ADD,
            BNJ_NONE, 4'b0000, 2'b10, MEM_LB, 3'b111, 5'd31,
            1'b0, 32'd0, 32'h1008, 32'h300, MEM_SW, 3'b000, 5'd20});
        add_row("flush_stall", row_t'{32'h100, 32'd1, 32'd2, 32'd0, OPER1_RS1, OPER2_RS2,
            ALU_ADD, BNJ_NONE, 4'b0000, 2'b11, MEM_LB, 3'b111, 5'd31,
            1'b0, 32'd0, 32'd0, 32'd0, MEM_NOP, 3'b000, 5'd0});
        add_row("after_flush", row_t'{32'h100, 32'd1, 32'd2, 32'd0, OPER1_RS1, OPER2_RS2,
            ALU_ADD, BNJ_NONE, 4'b0000, 2'b00, MEM_LB, 3'b111, 5'd31,
            1'b0, 32'd0, 32'd3, 32'd2, MEM_LB, 3'b111, 5'd31});
        add_row("flush", row_t'{32'h100, 32'd1, 32'd2, 32'd0, OPER1_RS1, OPER2_RS2, ALU_ADD,
            BNJ_NONE, 4'b0000, 2'b01, MEM_LB, 3'b111, 5'd31,
            1'b0, 32'd0, 32'd0, 32'd0, MEM_NOP, 3'b000, 5'd0});
    endtask

    task automatic add_random_rows();
        word_t       a;
        word_t       b;
        alu_oper_t   op;
        reg_addr_t   rd;
        logic [31:0] pick;
        for (int k = 0; k < N_RANDOM; k++)
        begin
            a    = $random(seed);
            b    = $random(seed);
            pick = $unsigned($random(seed)) % 32'd14;
            op   = alu_oper_t'(pick[3:0]);
            rd   = reg_addr_t'(k + 16);
            add_row($sformatf("random_%0d", k), row_t'{32'h100, a, b, 32'd0, OPER1_RS1,
                OPER2_RS2, op, BNJ_NONE, 4'b0000, 2'b00, MEM_LW, 3'b011, rd,
                1'b0, 32'd0, alu_model(op, a, b), b, MEM_LW, 3'b011, rd});
        end
    endtask

    task automatic apply_row(input row_t r);
        pc_i                 = r.pc;
        rs1_data_i           = r.rs1;
        rs2_data_i           = r.rs2;
        imm_i                = r.imm;
        alu_oper1_src_i      = r.src1;
        alu_oper2_src_i      = r.src2;
        alu_oper_i           = r.op;
        bnj_oper_i           = r.bnj;
        forward_ex_mem_rs1_i = r.fwd[3];
        forward_ex_mem_rs2_i = r.fwd[2];
        forward_mem_wb_rs1_i = r.fwd[1];
        forward_mem_wb_rs2_i = r.fwd[0];
        stall_i              = r.ctl[1];
        flush_i              = r.ctl[0];
        mem_oper_i           = r.mem;
        trap_i               = r.side[2];
        wb_use_mem_i         = r.side[1];
        write_rd_i           = r.side[0];
        rd_addr_i            = r.rd;
    endtask

    task automatic check_redirect(input string name, input row_t r);
        check_bit(name, "load_pc_o", r.exp_load_pc, load_pc_o);
        check_word(name, "new_pc_o", r.exp_new_pc, new_pc_o);
    endtask

    task automatic check_registered(input string name, input row_t r);
        check_word(name, "alu_result_o", r.exp_result, alu_result_o);
        check_word(name, "alu_oper2_o", r.exp_oper2, alu_oper2_o);
        check_mem_oper(name, r.exp_mem, mem_oper_o);
        check_bit(name, "trap_o", r.exp_side[2], trap_o);
        check_bit(name, "wb_use_mem_o", r.exp_side[1], wb_use_mem_o);
        check_bit(name, "write_rd_o", r.exp_side[0], write_rd_o);
        check_rd(name, r.exp_rd, rd_addr_o);
    endtask

    // watchdog sized from the table length
    initial
    begin
        #((N_FIXED + N_RANDOM + 20) * 10);
        stop_with_failure("timeout, the test table did not complete in time");
    end

    initial
    begin
        row_t busy;

        clk_i                 = 1'b0;
        rstn_i                = 1'b0;
        seed                  = 32'h3a7b76b6;
        forward_ex_mem_data_i = EX_MEM_DATA;
        forward_mem_wb_data_i = MEM_WB_DATA;
        apply_row('0);
        build_table();
        add_random_rows();

        // busy inputs so that only the reset keeps EX/MEM clear
        busy      = '0;
        busy.rs1  = 32'd1;
        busy.rs2  = 32'd2;
        busy.mem  = MEM_LW;
        busy.side = 3'b111;
        busy.rd   = 5'd31;
        apply_row(busy);

        // an all zero row doubles as the reset expectation
        repeat (4) @(posedge clk_i);
        #1;
        check_registered("in_reset", '0);
        check_redirect("in_reset", '0);

        // stall across the release keeps the reset values
        busy.ctl = 2'b10;
        apply_row(busy);
        repeat (4) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        @(posedge clk_i);
        #1;
        check_registered("after_reset", '0);
        check_redirect("after_reset", '0);

        // redirect is checked before the edge and EX/MEM just after it
        for (int i = 0; i < rows.size(); i++)
        begin
            apply_row(rows[i]);
            #4;
            check_redirect(names[i], rows[i]);
            @(posedge clk_i);
            #1;
            check_registered(names[i], rows[i]);
        end

        $display("All tests passed");
        $finish;
    end

endmodule : execute_tb

`default_nettype wire

//--- tb/execute_sva.sv
// assertions on the execute stage EX/MEM registers and the redirect output
`timescale 1ns/1ns
`default_nettype none

module execute_sva
(
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 stall_i,
    input  logic                 flush_i,
    input  riscv_pkg::bnj_oper_t bnj_oper_i,
    input  logic                 load_pc_o,
    input  riscv_pkg::word_t     alu_result_o,
    input  riscv_pkg::word_t     alu_oper2_o,
    input  riscv_pkg::mem_oper_t mem_oper_o,
    input  logic                 trap_o,
    input  logic                 wb_use_mem_o,
    input  logic                 write_rd_o,
    input  riscv_pkg::reg_addr_t rd_addr_o
);

    import riscv_pkg::*;

    // a flushed slot becomes a bubble
    flush_makes_bubble: assert property (@(posedge clk_i) disable iff (!rstn_i)
        flush_i |=> (!write_rd_o && mem_oper_o == MEM_NOP))
    else $error("flush did not clear write_rd_o and mem_oper_o");

    stall_holds_regs: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (stall_i && !flush_i) |=> ($stable(alu_result_o) && $stable(alu_oper2_o)
            && $stable(mem_oper_o) && $stable(trap_o) && $stable(wb_use_mem_o)
            && $stable(write_rd_o) && $stable(rd_addr_o)))
    else $error("EX/MEM registers changed during a stall");

    no_redirect_without_bnj: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (bnj_oper_i == BNJ_NONE) |-> !load_pc_o)
    else $error("load_pc_o high without a branch or jump");

endmodule : execute_sva

bind execute execute_sva u_execute_sva (.*);

`default_nettype wire

//--- rtl/execute.sv
// execute stage top connecting operand select, ALU, branch target and commit
`timescale 1ns/1ns
`default_nettype none

module execute
(
    input  logic                      clk_i,
    input  logic                      rstn_i,

    // from ID/EX
    input  riscv_pkg::word_t          pc_i,
    input  riscv_pkg::word_t          rs1_data_i,
    input  riscv_pkg::word_t          rs2_data_i,
    input  riscv_pkg::word_t          imm_i,
    input  riscv_pkg::alu_oper1_src_t alu_oper1_src_i,
    input  riscv_pkg::alu_oper2_src_t alu_oper2_src_i,
    input  riscv_pkg::alu_oper_t      alu_oper_i,
    input  riscv_pkg::bnj_oper_t      bnj_oper_i,

    // sideband for MEM and WB
    input  riscv_pkg::mem_oper_t      mem_oper_i,
    input  logic                      trap_i,
    input  logic                      wb_use_mem_i,
    input  logic                      write_rd_i,
    input  riscv_pkg::reg_addr_t      rd_addr_i,

    input  logic                      stall_i,
    input  logic                      flush_i,

    // EX/MEM registers
    output riscv_pkg::word_t          alu_result_o,
    output riscv_pkg::word_t          alu_oper2_o,
    output riscv_pkg::mem_oper_t      mem_oper_o,
    output logic                      trap_o,
    output logic                      wb_use_mem_o,
    output logic                      write_rd_o,
    output riscv_pkg::reg_addr_t      rd_addr_o,

    // redirect
    output logic                      load_pc_o,
    output riscv_pkg::word_t          new_pc_o,

    // forwarding selects from the hazard unit
    input  logic                      forward_ex_mem_rs1_i,
    input  logic                      forward_ex_mem_rs2_i,
    input  riscv_pkg::word_t          forward_ex_mem_data_i,
    input  logic                      forward_mem_wb_rs1_i,
    input  logic                      forward_mem_wb_rs2_i,
    input  riscv_pkg::word_t          forward_mem_wb_data_i
);

    import riscv_pkg::*;

    word_t operand1;
    word_t operand2;
    word_t fwd_rs1;
    word_t fwd_rs2;
    word_t alu_result;
    word_t target;
    logic  jump_req;
    logic  branch_req;

    operand_select u_operand_select (
        .pc_i                  (pc_i),
        .rs1_data_i            (rs1_data_i),
        .rs2_data_i            (rs2_data_i),
        .imm_i                 (imm_i),
        .alu_oper1_src_i       (alu_oper1_src_i),
        .alu_oper2_src_i       (alu_oper2_src_i),
        .forward_ex_mem_rs1_i  (forward_ex_mem_rs1_i),
        .forward_ex_mem_rs2_i  (forward_ex_mem_rs2_i),
        .forward_mem_wb_rs1_i  (forward_mem_wb_rs1_i),
        .forward_mem_wb_rs2_i  (forward_mem_wb_rs2_i),
        .forward_ex_mem_data_i (forward_ex_mem_data_i),
        .forward_mem_wb_data_i (forward_mem_wb_data_i),
        .operand1_o            (operand1),
        .operand2_o            (operand2),
        .fwd_rs1_o             (fwd_rs1),
        .fwd_rs2_o             (fwd_rs2)
    );

    alu u_alu (
        .operand1_i   (operand1),
        .operand2_i   (operand2),
        .alu_oper_i   (alu_oper_i),
        .alu_result_o (alu_result)
    );

    // works beside the ALU on the same cycle
    branch_target u_branch_target (
        .pc_i         (pc_i),
        .imm_i        (imm_i),
        .rs1_i        (fwd_rs1),
        .bnj_oper_i   (bnj_oper_i),
        .jump_req_o   (jump_req),
        .branch_req_o (branch_req),
        .target_o     (target)
    );

    ex_commit u_ex_commit (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .alu_result_i (alu_result),
        .rs2_i        (fwd_rs2),
        .target_i     (target),
        .jump_req_i   (jump_req),
        .branch_req_i (branch_req),
        .mem_oper_i   (mem_oper_i),
        .trap_i       (trap_i),
        .wb_use_mem_i (wb_use_mem_i),
        .write_rd_i   (write_rd_i),
        .rd_addr_i    (rd_addr_i),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .load_pc_o    (load_pc_o),
        .new_pc_o     (new_pc_o),
        .alu_result_o (alu_result_o),
        .alu_oper2_o  (alu_oper2_o),
        .mem_oper_o   (mem_oper_o),
        .trap_o       (trap_o),
        .wb_use_mem_o (wb_use_mem_o),
        .write_rd_o   (write_rd_o),
        .rd_addr_o    (rd_addr_o)
    );

endmodule : execute

`default_nettype wire

//--- rtl/ex_commit.sv
// redirect decision and EX/MEM pipeline registers of the execute stage
`timescale 1ns/1ns
`default_nettype none

module ex_commit
(
    input  logic                 clk_i,
    input  logic                 rstn_i,

    input  riscv_pkg::word_t     alu_result_i,
    input  riscv_pkg::word_t     rs2_i,
    input  riscv_pkg::word_t     target_i,
    input  logic                 jump_req_i,
    input  logic                 branch_req_i,

    input  riscv_pkg::mem_oper_t mem_oper_i,
    input  logic                 trap_i,
    input  logic                 wb_use_mem_i,
    input  logic                 write_rd_i,
    input  riscv_pkg::reg_addr_t rd_addr_i,

    input  logic                 stall_i,
    input  logic                 flush_i,

    output logic                 load_pc_o,
    output riscv_pkg::word_t     new_pc_o,

    output riscv_pkg::word_t     alu_result_o,
    output riscv_pkg::word_t     alu_oper2_o,
    output riscv_pkg::mem_oper_t mem_oper_o,
    output logic                 trap_o,
    output logic                 wb_use_mem_o,
    output logic                 write_rd_o,
    output riscv_pkg::reg_addr_t rd_addr_o
);

    import riscv_pkg::*;

    // branch condition comes from the compare in bit 0
    assign load_pc_o = jump_req_i | (branch_req_i & alu_result_i[0]);
    assign new_pc_o  = load_pc_o ? target_i : '0;

    // flush beats stall, stall holds everything
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            alu_result_o <= '0;
            alu_oper2_o  <= '0;
            mem_oper_o   <= MEM_NOP;
            trap_o       <= 1'b0;
            wb_use_mem_o <= 1'b0;
            write_rd_o   <= 1'b0;
            rd_addr_o    <= '0;
        end
        else if (flush_i)
        begin
            alu_result_o <= '0;
            alu_oper2_o  <= '0;
            mem_oper_o   <= MEM_NOP;
            trap_o       <= 1'b0;
            wb_use_mem_o <= 1'b0;
            write_rd_o   <= 1'b0;
            rd_addr_o    <= '0;
        end
        else if (!stall_i)
        begin
            alu_result_o <= alu_result_i;
            // store data for the memory stage
            alu_oper2_o  <= rs2_i;
            mem_oper_o   <= mem_oper_i;
            trap_o       <= trap_i;
            wb_use_mem_o <= wb_use_mem_i;
            write_rd_o   <= write_rd_i;
            rd_addr_o    <= rd_addr_i;
        end
    end

endmodule : ex_commit

`default_nettype wire

//--- rtl/branch_target.sv
// branch and jump classification with redirect target computation
`timescale 1ns/1ns
`default_nettype none

module branch_target
(
    input  riscv_pkg::word_t     pc_i,
    input  riscv_pkg::word_t     imm_i,
    input  riscv_pkg::word_t     rs1_i,
    input  riscv_pkg::bnj_oper_t bnj_oper_i,
    output logic                 jump_req_o,
    output logic                 branch_req_o,
    output riscv_pkg::word_t     target_o
);

    import riscv_pkg::*;

    word_t base;

    // jalr is relative to the forwarded rs1, the rest to the pc
    assign base     = (bnj_oper_i == BNJ_JALR) ? rs1_i : pc_i;
    assign target_o = base + imm_i;

    always_comb
    begin
        case (bnj_oper_i)
            BNJ_JAL,
            BNJ_JALR:
            begin
                jump_req_o   = 1'b1;
                branch_req_o = 1'b0;
            end
            BNJ_BRANCH:
            begin
                jump_req_o   = 1'b0;
                branch_req_o = 1'b1;
            end
            default:
            begin
                jump_req_o   = 1'b0;
                branch_req_o = 1'b0;
            end
        endcase
    end

endmodule : branch_target

`default_nettype wire

//--- rtl/alu.sv
// integer ALU for add, subtract, compare, logic and shift operations
`timescale 1ns/1ns
`default_nettype none

module alu
(
    input  riscv_pkg::word_t     operand1_i,
    input  riscv_pkg::word_t     operand2_i,
    input  riscv_pkg::alu_oper_t alu_oper_i,
    output riscv_pkg::word_t     alu_result_o
);

    import riscv_pkg::*;

    shamt_t shamt;

    // only the low five bits count for rv32 shifts
    assign shamt = operand2_i[4:0];

    always_comb
    begin
        case (alu_oper_i)
            ALU_ADD:  alu_result_o = operand1_i + operand2_i;
            ALU_SUB:  alu_result_o = operand1_i - operand2_i;

            ALU_SEQ:  alu_result_o = {31'd0, operand1_i == operand2_i};
            ALU_SNEQ: alu_result_o = {31'd0, operand1_i != operand2_i};

            // signed compares
            ALU_SLT:  alu_result_o = {31'd0, $signed(operand1_i) < $signed(operand2_i)};
            ALU_SGE:  alu_result_o = {31'd0, $signed(operand1_i) >= $signed(operand2_i)};

            ALU_SLTU: alu_result_o = {31'd0, operand1_i < operand2_i};
            ALU_SGEU: alu_result_o = {31'd0, operand1_i >= operand2_i};

            ALU_XOR:  alu_result_o = operand1_i ^ operand2_i;
            ALU_OR:   alu_result_o = operand1_i | operand2_i;
            ALU_AND:  alu_result_o = operand1_i & operand2_i;

            ALU_SLL:  alu_result_o = operand1_i << shamt;
            ALU_SRL:  alu_result_o = operand1_i >> shamt;
            // arithmetic shift keeps the sign bit
            ALU_SRA:  alu_result_o = word_t'($signed(operand1_i) >>> shamt);

            default:  alu_result_o = operand1_i + operand2_i;
        endcase
    end

endmodule : alu

`default_nettype wire

//--- rtl/operand_select.sv
// operand select with EX/MEM and MEM/WB forwarding for both source registers
`timescale 1ns/1ns
`default_nettype none

module operand_select
(
    input  riscv_pkg::word_t          pc_i,
    input  riscv_pkg::word_t          rs1_data_i,
    input  riscv_pkg::word_t          rs2_data_i,
    input  riscv_pkg::word_t          imm_i,
    input  riscv_pkg::alu_oper1_src_t alu_oper1_src_i,
    input  riscv_pkg::alu_oper2_src_t alu_oper2_src_i,

    input  logic                      forward_ex_mem_rs1_i,
    input  logic                      forward_ex_mem_rs2_i,
    input  logic                      forward_mem_wb_rs1_i,
    input  logic                      forward_mem_wb_rs2_i,
    input  riscv_pkg::word_t          forward_ex_mem_data_i,
    input  riscv_pkg::word_t          forward_mem_wb_data_i,

    output riscv_pkg::word_t          operand1_o,
    output riscv_pkg::word_t          operand2_o,
    output riscv_pkg::word_t          fwd_rs1_o,
    output riscv_pkg::word_t          fwd_rs2_o
);

    import riscv_pkg::*;

    // the younger result in EX/MEM wins over MEM/WB
    always_comb
    begin
        if (forward_ex_mem_rs1_i)
            fwd_rs1_o = forward_ex_mem_data_i;
        else if (forward_mem_wb_rs1_i)
            fwd_rs1_o = forward_mem_wb_data_i;
        else
            fwd_rs1_o = rs1_data_i;
    end

    always_comb
    begin
        if (forward_ex_mem_rs2_i)
            fwd_rs2_o = forward_ex_mem_data_i;
        else if (forward_mem_wb_rs2_i)
            fwd_rs2_o = forward_mem_wb_data_i;
        else
            fwd_rs2_o = rs2_data_i;
    end

    always_comb
    begin
        case (alu_oper1_src_i)
            OPER1_RS1:  operand1_o = fwd_rs1_o;
            OPER1_PC:   operand1_o = pc_i;
            OPER1_ZERO: operand1_o = '0;
            default:    operand1_o = fwd_rs1_o;
        endcase
    end

    // PC_INC gives the link address together with OPER1_PC
    always_comb
    begin
        case (alu_oper2_src_i)
            OPER2_RS2:    operand2_o = fwd_rs2_o;
            OPER2_IMM:    operand2_o = imm_i;
            OPER2_PC_INC: operand2_o = PC_INC;
            default:      operand2_o = fwd_rs2_o;
        endcase
    end

endmodule : operand_select

`default_nettype wire

//--- rtl/riscv_pkg.sv
// rv32i execute stage package with shared word types and operation codes
`default_nettype none

package riscv_pkg;

    // data and address word
    typedef logic [31:0] word_t;

    // register file index
    typedef logic [4:0] reg_addr_t;

    // shift amount taken from operand 2
    typedef logic [4:0] shamt_t;

    // link offset, no compressed instructions
    localparam word_t PC_INC = 32'd4;

    typedef enum logic [1:0] {
        OPER1_RS1  = 2'd0,
        OPER1_PC   = 2'd1,
        OPER1_ZERO = 2'd2
    } alu_oper1_src_t;

    typedef enum logic [1:0] {
        OPER2_RS2    = 2'd0,
        OPER2_IMM    = 2'd1,
        OPER2_PC_INC = 2'd2
    } alu_oper2_src_t;

    // compares return their flag in bit 0
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SEQ  = 4'd2,
        ALU_SNEQ = 4'd3,
        ALU_SLT  = 4'd4,
        ALU_SGE  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SGEU = 4'd7,
        ALU_XOR  = 4'd8,
        ALU_OR   = 4'd9,
        ALU_AND  = 4'd10,
        ALU_SLL  = 4'd11,
        ALU_SRL  = 4'd12,
        ALU_SRA  = 4'd13
    } alu_oper_t;

    typedef enum logic [1:0] {
        BNJ_NONE   = 2'd0,
        BNJ_JAL    = 2'd1,
        BNJ_JALR   = 2'd2,
        BNJ_BRANCH = 2'd3
    } bnj_oper_t;

    // passed through to the memory stage
    typedef enum logic [3:0] {
        MEM_NOP = 4'd0,
        MEM_LB  = 4'd1,
        MEM_LH  = 4'd2,
        MEM_LW  = 4'd3,
        MEM_LBU = 4'd4,
        MEM_LHU = 4'd5,
        MEM_SB  = 4'd6,
        MEM_SH  = 4'd7,
        MEM_SW  = 4'd8
    } mem_oper_t;

endpackage : riscv_pkg

`default_nettype wire
